/* design/wb_ram.sv */
// Wishbone classic RAM with byte selects and a one-cycle registered ack
`timescale 1ns/1ns
`include "xfcp_params.svh"

module wb_ram import xfcp_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  wb_req_t wb_i,
    output wb_rsp_t wb_o
);

    logic [`WB_DATA_W-1:0] mem [2**`WB_ADDR_W];
    logic [`WB_DATA_W-1:0] rd_data;
    logic                  ack;
    logic                  access;

    // New access only while no ack is out
    assign access = wb_i.cyc && wb_i.stb && !ack;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                for (int b = 0; b < `WB_SEL_W; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[wb_i.adr][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
            rd_data <= mem[wb_i.adr];
        end
    end

    assign wb_o = '{dat: rd_data, ack: ack};

endmodule

/* design/xfcp_core.sv */
// XFCP core with request switch, per-port Wishbone bridges and RAMs, response merge
`timescale 1ns/1ns
`include "xfcp_params.svh"

module xfcp_core import xfcp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  xfcp_stream_t up_in_i,
    input  logic         up_in_valid_i,
    output logic         up_in_ready_o,
    output xfcp_stream_t up_out_o,
    output logic         up_out_valid_o,
    input  logic         up_out_ready_i
);

    xfcp_stream_t [`XFCP_PORTS-1:0] dn_req;
    logic [`XFCP_PORTS-1:0]         dn_req_valid;
    logic [`XFCP_PORTS-1:0]         dn_req_ready;
    xfcp_stream_t [`XFCP_PORTS-1:0] dn_rsp;
    logic [`XFCP_PORTS-1:0]         dn_rsp_valid;
    logic [`XFCP_PORTS-1:0]         dn_rsp_ready;

    xfcp_switch_down switch_down_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (up_in_i),
        .in_valid_i  (up_in_valid_i),
        .in_ready_o  (up_in_ready_o),
        .out_o       (dn_req),
        .out_valid_o (dn_req_valid),
        .out_ready_i (dn_req_ready)
    );

    // One bridge and RAM per port
    for (genvar p = 0; p < `XFCP_PORTS; p++) begin : g_port
        wb_req_t wb_req;
        wb_rsp_t wb_rsp;

        xfcp_wb_bridge bridge_inst (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .req_i       (dn_req[p]),
            .req_valid_i (dn_req_valid[p]),
            .req_ready_o (dn_req_ready[p]),
            .rsp_o       (dn_rsp[p]),
            .rsp_valid_o (dn_rsp_valid[p]),
            .rsp_ready_i (dn_rsp_ready[p]),
            .wb_o        (wb_req),
            .wb_i        (wb_rsp)
        );

        wb_ram ram_inst (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .wb_i    (wb_req),
            .wb_o    (wb_rsp)
        );
    end

    xfcp_switch_up switch_up_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_i        (dn_rsp),
        .in_valid_i  (dn_rsp_valid),
        .in_ready_o  (dn_rsp_ready),
        .out_o       (up_out_o),
        .out_valid_o (up_out_valid_o),
        .out_ready_i (up_out_ready_i)
    );

endmodule

/* design/xfcp_params.svh */
// Port count, Wishbone bus widths and XFCP command codes
`ifndef XFCP_PARAMS_SVH
`define XFCP_PARAMS_SVH

// Downstream ports behind the switch
`define XFCP_PORTS 3

// Wishbone geometry, word addressed
`define WB_ADDR_W 8
`define WB_DATA_W 32
`define WB_SEL_W 4

// Request commands
// Responses carry the request code plus one
`define XFCP_CMD_READ 8'h10
`define XFCP_CMD_WRITE 8'h12

`endif

/* design/xfcp_pkg.sv */
// Stream beat and Wishbone master/slave struct types
`include "xfcp_params.svh"

package xfcp_pkg;

    // One byte of an XFCP packet
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
    } xfcp_stream_t;

    // Master side of a classic Wishbone link
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_DATA_W-1:0] dat;
        logic                  we;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  stb;
        logic                  cyc;
    } wb_req_t;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  ack;
    } wb_rsp_t;

endpackage

/* design/xfcp_switch_down.sv */
// Request switch routing each packet to the port named by its first byte
`timescale 1ns/1ns
`include "xfcp_params.svh"

module xfcp_switch_down import xfcp_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  xfcp_stream_t                     in_i,
    input  logic                             in_valid_i,
    output logic                             in_ready_o,
    output xfcp_stream_t [`XFCP_PORTS-1:0]   out_o,
    output logic [`XFCP_PORTS-1:0]           out_valid_o,
    input  logic [`XFCP_PORTS-1:0]           out_ready_i
);

    localparam int PORT_W = (`XFCP_PORTS > 1) ? $clog2(`XFCP_PORTS) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FWD,
        S_DROP
    } state_t;

    state_t           state;
    logic [PORT_W-1:0] sel;
    xfcp_stream_t     out_reg;
    logic             out_valid;
    logic             out_take;
    logic             in_take;

    assign out_take = out_valid && out_ready_i[sel];
    assign in_take  = in_valid_i && in_ready_o;

    // Discarded packets never wait on a port
    always_comb begin
        case (state)
            S_DROP:  in_ready_o = 1'b1;
            default: in_ready_o = !out_valid || out_ready_i[sel];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= S_IDLE;
            sel       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_take) begin
                out_valid <= 1'b0;
            end
            if (in_take) begin
                case (state)
                    S_IDLE: begin
                        // Port byte is stripped here
                        if (!in_i.tlast) begin
                            if (in_i.tdata < 8'(`XFCP_PORTS)) begin
                                sel   <= in_i.tdata[PORT_W-1:0];
                                state <= S_FWD;
                            end else begin
                                state <= S_DROP;
                            end
                        end
                    end
                    S_FWD: begin
                        out_valid <= 1'b1;
                        if (in_i.tlast) begin
                            state <= S_IDLE;
                        end
                    end
                    default: begin
                        if (in_i.tlast) begin
                            state <= S_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_take && state == S_FWD) begin
            out_reg <= in_i;
        end
    end

    // Same beat on every port, valid only on the locked one
    always_comb begin
        for (int p = 0; p < `XFCP_PORTS; p++) begin
            out_o[p]       = out_reg;
            out_valid_o[p] = out_valid && (sel == PORT_W'(p));
        end
    end

endmodule

/* design/xfcp_switch_up.sv */
// Round-robin response merge that prefixes each packet with its port index
`timescale 1ns/1ns
`include "xfcp_params.svh"

module xfcp_switch_up import xfcp_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  xfcp_stream_t [`XFCP_PORTS-1:0]   in_i,
    input  logic [`XFCP_PORTS-1:0]           in_valid_i,
    output logic [`XFCP_PORTS-1:0]           in_ready_o,
    output xfcp_stream_t                     out_o,
    output logic                             out_valid_o,
    input  logic                             out_ready_i
);

    localparam int PORT_W = (`XFCP_PORTS > 1) ? $clog2(`XFCP_PORTS) : 1;

    logic              busy;
    logic [PORT_W-1:0] grant;
    logic [PORT_W-1:0] prio;
    logic [PORT_W-1:0] pick;
    logic              found;
    xfcp_stream_t      out_reg;
    logic              out_valid;
    logic              out_free;
    logic              in_take;

    assign out_free = !out_valid || out_ready_i;
    assign in_take  = busy && in_valid_i[grant] && out_free;

    // Lowest offset from prio wins, so scan from the far end
    always_comb begin
        int cand;
        pick  = prio;
        found = 1'b0;
        for (int k = `XFCP_PORTS - 1; k >= 0; k--) begin
            cand = (int'(prio) + k) % `XFCP_PORTS;
            if (in_valid_i[cand]) begin
                pick  = PORT_W'(cand);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        in_ready_o = '0;
        if (busy) begin
            in_ready_o[grant] = out_free;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy      <= 1'b0;
            grant     <= '0;
            prio      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_ready_i) begin
                out_valid <= 1'b0;
            end
            if (!busy && found && out_free) begin
                // Index byte goes out first
                busy      <= 1'b1;
                grant     <= pick;
                out_valid <= 1'b1;
            end
            if (in_take) begin
                out_valid <= 1'b1;
                if (in_i[grant].tlast) begin
                    busy <= 1'b0;
                    prio <= (grant == PORT_W'(`XFCP_PORTS - 1)) ? '0 : grant + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && found && out_free) begin
            out_reg <= '{tdata: 8'(pick), tlast: 1'b0};
        end else if (in_take) begin
            out_reg <= in_i[grant];
        end
    end

    assign out_o       = out_reg;
    assign out_valid_o = out_valid;

endmodule

/* design/xfcp_wb_bridge.sv */
// Bridge from XFCP read/write packets to Wishbone classic cycles
`timescale 1ns/1ns
`include "xfcp_params.svh"

module xfcp_wb_bridge import xfcp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  xfcp_stream_t req_i,
    input  logic         req_valid_i,
    output logic         req_ready_o,
    output xfcp_stream_t rsp_o,
    output logic         rsp_valid_o,
    input  logic         rsp_ready_i,
    output wb_req_t      wb_o,
    input  wb_rsp_t      wb_i
);

    typedef enum logic [3:0] {
        S_CMD,
        S_ADDR,
        S_CNT,
        S_WDATA,
        S_WB,
        S_HDR,
        S_RDATA,
        S_SKIP,
        S_DROP
    } state_t;

    state_t                state;
    logic [7:0]            cmd;
    logic [7:0]            addr_start;
    logic [7:0]            count;
    logic [7:0]            words_left;
    logic [1:0]            idx;
    logic                  pkt_end;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] word;
    logic                  stb;
    xfcp_stream_t          rsp;
    xfcp_stream_t          rsp_next;
    logic                  rsp_valid;
    logic                  rsp_load;
    logic                  req_take;
    logic                  is_write;

    assign is_write = (cmd == `XFCP_CMD_WRITE);
    assign req_take = req_valid_i && req_ready_o;
    assign rsp_load = (state == S_HDR || state == S_RDATA) && (!rsp_valid || rsp_ready_i);

    assign req_ready_o = (state == S_CMD) || (state == S_ADDR) || (state == S_CNT) ||
                         (state == S_WDATA) || (state == S_SKIP) || (state == S_DROP);

    assign rsp_o       = rsp;
    assign rsp_valid_o = rsp_valid;
    assign wb_o = '{adr: adr, dat: word, we: is_write, sel: {`WB_SEL_W{1'b1}},
                    stb: stb, cyc: stb};

    // Header is cmd+1, address, count; read data follows LSB first
    always_comb begin
        if (state == S_HDR) begin
            case (idx)
                2'd0:    rsp_next = '{tdata: cmd + 8'd1, tlast: 1'b0};
                2'd1:    rsp_next = '{tdata: addr_start, tlast: 1'b0};
                default: rsp_next = '{tdata: count, tlast: is_write || count == 8'd0};
            endcase
        end else begin
            rsp_next = '{tdata: word[8*idx +: 8], tlast: idx == 2'd3 && words_left == 8'd0};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= S_CMD;
            idx        <= 2'd0;
            words_left <= 8'd0;
            pkt_end    <= 1'b0;
            stb        <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            if (rsp_load) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid <= 1'b0;
            end
            case (state)
                S_CMD: begin
                    if (req_take && !req_i.tlast) begin
                        if (req_i.tdata == `XFCP_CMD_READ || req_i.tdata == `XFCP_CMD_WRITE) begin
                            state <= S_ADDR;
                        end else begin
                            state <= S_DROP;
                        end
                    end
                end
                S_ADDR: begin
                    if (req_take) begin
                        state <= req_i.tlast ? S_CMD : S_CNT;
                    end
                end
                S_CNT: begin
                    if (req_take) begin
                        words_left <= req_i.tdata;
                        idx        <= 2'd0;
                        if (is_write && req_i.tdata != 8'd0) begin
                            state <= req_i.tlast ? S_CMD : S_WDATA;
                        end else begin
                            state <= req_i.tlast ? S_HDR : S_SKIP;
                        end
                    end
                end
                S_WDATA: begin
                    if (req_take) begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd3) begin
                            if (req_i.tlast && words_left != 8'd1) begin
                                state <= S_CMD;
                            end else begin
                                pkt_end <= req_i.tlast;
                                stb     <= 1'b1;
                                state   <= S_WB;
                            end
                        end else if (req_i.tlast) begin
                            // Short write data is dropped
                            state <= S_CMD;
                        end
                    end
                end
                S_WB: begin
                    if (wb_i.ack) begin
                        stb        <= 1'b0;
                        words_left <= words_left - 8'd1;
                        idx        <= 2'd0;
                        if (!is_write) begin
                            state <= S_RDATA;
                        end else if (words_left != 8'd1) begin
                            state <= S_WDATA;
                        end else begin
                            state <= pkt_end ? S_HDR : S_SKIP;
                        end
                    end
                end
                S_HDR: begin
                    if (rsp_load) begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd2) begin
                            idx <= 2'd0;
                            if (is_write || count == 8'd0) begin
                                state <= S_CMD;
                            end else begin
                                stb   <= 1'b1;
                                state <= S_WB;
                            end
                        end
                    end
                end
                S_RDATA: begin
                    // Next read starts once the last byte is loaded
                    if (rsp_load) begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd3) begin
                            if (words_left == 8'd0) begin
                                state <= S_CMD;
                            end else begin
                                stb   <= 1'b1;
                                state <= S_WB;
                            end
                        end
                    end
                end
                S_SKIP: begin
                    if (req_take && req_i.tlast) begin
                        idx   <= 2'd0;
                        state <= S_HDR;
                    end
                end
                default: begin
                    if (req_take && req_i.tlast) begin
                        state <= S_CMD;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            case (state)
                S_CMD:   cmd <= req_i.tdata;
                S_ADDR: begin
                    addr_start <= req_i.tdata;
                    adr        <= req_i.tdata;
                end
                S_CNT:   count <= req_i.tdata;
                S_WDATA: word[8*idx +: 8] <= req_i.tdata;
                default: ;
            endcase
        end
        if (state == S_WB && wb_i.ack) begin
            adr <= adr + 1'b1;
            if (!is_write) begin
                word <= wb_i.dat;
            end
        end
        if (rsp_load) begin
            rsp <= rsp_next;
        end
    end

endmodule

/* list.f */
+incdir+design
design/xfcp_pkg.sv
design/wb_ram.sv
design/xfcp_switch_down.sv
design/xfcp_switch_up.sv
design/xfcp_wb_bridge.sv
design/xfcp_core.sv
testbench/tb_xfcp_core.sv

/* testbench/tb_xfcp_core.sv */
// Testbench for xfcp_core with RAM model, response collector and random back-pressure
`timescale 1ns/1ns
`include "xfcp_params.svh"

module tb_xfcp_core import xfcp_pkg::*; ();

    localparam int BEAT_TIMEOUT = 200;
    localparam int RSP_TIMEOUT  = 3000;

    logic                   clk;
    logic                   rst_n_i;
    xfcp_stream_t           up_in_i;
    logic                   up_in_valid_i;
    logic                   up_in_ready_o;
    xfcp_stream_t           up_out_o;
    logic                   up_out_valid_o;
    logic                   up_out_ready_i;

    logic [31:0]            rng_state;
    logic [31:0]            rdy_state;
    logic                   rand_ready;
    logic [31:0]            model_mem [`XFCP_PORTS][256];
    logic [7:0]             req_buf [128];
    logic [7:0]             exp_buf [`XFCP_PORTS][128];
    int                     exp_len [`XFCP_PORTS];
    logic [`XFCP_PORTS-1:0] pending;
    logic [7:0]             rx_buf [128];
    int                     rx_len;
    int                     rsp_count;
    int                     err_count;
    int                     test_err_start;
    int                     n_pass;
    int                     n_fail;
    string                  test_name;

    xfcp_core uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .up_in_i        (up_in_i),
        .up_in_valid_i  (up_in_valid_i),
        .up_in_ready_o  (up_in_ready_o),
        .up_out_o       (up_out_o),
        .up_out_valid_o (up_out_valid_o),
        .up_out_ready_i (up_out_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Request bytes into req_buf with random write data
    function automatic int build_request(input int port, input logic [7:0] cmd,
                                         input logic [7:0] addr, input int count);
        int n;
        int i;
        int b;
        req_buf[0] = 8'(port);
        req_buf[1] = cmd;
        req_buf[2] = addr;
        req_buf[3] = 8'(count);
        n = 4;
        if (cmd == `XFCP_CMD_WRITE) begin
            for (i = 0; i < count; i++) begin
                rng_state = xorshift32(rng_state);
                for (b = 0; b < 4; b++) begin
                    req_buf[n] = rng_state[8*b +: 8];
                    n++;
                end
            end
        end
        return n;
    endfunction

    // Reference model of the RAMs and of the expected response bytes
    function automatic void model_request(input int len);
        int port;
        int cnt;
        int n;
        int i;
        int b;
        logic [7:0]  cmd;
        logic [7:0]  addr;
        logic [31:0] w;
        port = int'(req_buf[0]);
        cmd  = req_buf[1];
        addr = req_buf[2];
        cnt  = int'(req_buf[3]);
        if (len < 4 || port >= `XFCP_PORTS) return;
        if (cmd != `XFCP_CMD_READ && cmd != `XFCP_CMD_WRITE) return;
        if (cmd == `XFCP_CMD_WRITE && len < 4 + 4 * cnt) return;
        exp_buf[port][0] = 8'(port);
        exp_buf[port][1] = (cmd == `XFCP_CMD_WRITE) ? 8'h13 : 8'h11;
        exp_buf[port][2] = addr;
        exp_buf[port][3] = 8'(cnt);
        n = 4;
        for (i = 0; i < cnt; i++) begin
            if (cmd == `XFCP_CMD_WRITE) begin
                for (b = 0; b < 4; b++) begin
                    w[8*b +: 8] = req_buf[4 + 4 * i + b];
                end
                model_mem[port][(int'(addr) + i) % 256] = w;
            end else begin
                w = model_mem[port][(int'(addr) + i) % 256];
                for (b = 0; b < 4; b++) begin
                    exp_buf[port][n] = w[8*b +: 8];
                    n++;
                end
            end
        end
        exp_len[port] = n;
        pending[port] = 1'b1;
    endfunction

    task automatic send_packet(input int len);
        int i;
        int t;
        @(posedge clk);
        #2;
        for (i = 0; i < len; i++) begin
            up_in_i       = '{tdata: req_buf[i], tlast: (i == len - 1)};
            up_in_valid_i = 1'b1;
            t = 0;
            @(negedge clk);
            while (!up_in_ready_o && t < BEAT_TIMEOUT) begin
                @(negedge clk);
                t++;
            end
            if (!up_in_ready_o) begin
                $display("%s: request byte %0d was never accepted", test_name, i);
                err_count++;
            end
            @(posedge clk);
            #2;
        end
        up_in_valid_i = 1'b0;
        up_in_i       = '0;
    endtask

    task automatic run_request(input int port, input logic [7:0] cmd,
                               input logic [7:0] addr, input int count);
        int len;
        len = build_request(port, cmd, addr, count);
        model_request(len);
        send_packet(len);
    endtask

    task automatic wait_responses();
        int t;
        t = 0;
        while (pending != '0 && t < RSP_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (pending != '0) begin
            $display("%s: no complete response from ports %b within %0d cycles",
                     test_name, pending, RSP_TIMEOUT);
            err_count++;
            pending = '0;
        end
    endtask

    task automatic check_response();
        int port;
        int i;
        port = int'(rx_buf[0]);
        rsp_count++;
        if (port >= `XFCP_PORTS || !pending[port]) begin
            $display("%s: response for port %0d arrived while none was expected",
                     test_name, port);
            err_count++;
        end else begin
            if (rx_len != exp_len[port]) begin
                $display("ERR %s port %0d length expected %0d actual %0d",
                         test_name, port, exp_len[port], rx_len);
                err_count++;
            end
            for (i = 0; i < rx_len && i < exp_len[port]; i++) begin
                if (rx_buf[i] !== exp_buf[port][i]) begin
                    $display("ERR %s port %0d byte %0d expected %02h actual %02h",
                             test_name, port, i, exp_buf[port][i], rx_buf[i]);
                    err_count++;
                end
            end
            pending[port] = 1'b0;
        end
    endtask

    // Beats are sampled at negedge and transfer on the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n_i && up_out_valid_o && up_out_ready_i) begin
                if (rx_len < 128) begin
                    rx_buf[rx_len] = up_out_o.tdata;
                    rx_len++;
                end
                if (up_out_o.tlast) begin
                    check_response();
                    rx_len = 0;
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (rand_ready) begin
                rdy_state      = xorshift32(rdy_state);
                up_out_ready_i = rdy_state[7];
            end else begin
                up_out_ready_i = 1'b1;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        int errs;
        errs = err_count - test_err_start;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", test_name, errs);
            n_fail++;
        end
    endtask

    initial begin
        int t;
        int start;
        rst_n_i        = 1'b0;
        up_in_i        = '0;
        up_in_valid_i  = 1'b0;
        up_out_ready_i = 1'b1;
        rand_ready     = 1'b0;
        rng_state      = 32'd49580;
        rdy_state      = 32'd49580;
        pending        = '0;
        rx_len         = 0;
        rsp_count      = 0;
        err_count      = 0;
        n_pass         = 0;
        n_fail         = 0;

        begin_test("reset");
        for (t = 0; t < 13; t++) begin
            @(posedge clk);
            #2;
            if (t == 9) begin
                rst_n_i = 1'b1;
            end
            if (up_out_valid_o !== 1'b0) begin
                $display("ERR reset up_out_valid_o expected 0 actual %b", up_out_valid_o);
                err_count++;
            end
        end
        t = 0;
        while (!up_in_ready_o && t < BEAT_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!up_in_ready_o) begin
            $display("reset: up_in_ready_o did not rise after reset");
            err_count++;
        end
        end_test();

        begin_test("write_read");
        run_request(0, `XFCP_CMD_WRITE, 8'h10, 4);
        wait_responses();
        run_request(0, `XFCP_CMD_READ, 8'h10, 4);
        wait_responses();
        end_test();

        begin_test("isolation");
        run_request(1, `XFCP_CMD_WRITE, 8'h40, 3);
        wait_responses();
        run_request(2, `XFCP_CMD_WRITE, 8'h40, 3);
        wait_responses();
        run_request(1, `XFCP_CMD_READ, 8'h40, 3);
        wait_responses();
        run_request(2, `XFCP_CMD_READ, 8'h40, 3);
        wait_responses();
        end_test();

        begin_test("drop");
        start = rsp_count;
        run_request(3, `XFCP_CMD_READ, 8'h10, 2);
        run_request(0, 8'h20, 8'h10, 2);
        t = 0;
        while (rsp_count == start && t < RSP_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (rsp_count != start) begin
            $display("drop: a dropped packet produced a response");
            err_count++;
        end
        run_request(0, `XFCP_CMD_READ, 8'h10, 4);
        wait_responses();
        end_test();

        begin_test("wrap_backpressure");
        run_request(2, `XFCP_CMD_WRITE, 8'd250, 12);
        wait_responses();
        rand_ready = 1'b1;
        run_request(2, `XFCP_CMD_READ, 8'd250, 12);
        wait_responses();
        rand_ready = 1'b0;
        end_test();

        // Back-to-back requests matched by their port byte
        begin_test("interleave");
        start      = rsp_count;
        rand_ready = 1'b1;
        run_request(0, `XFCP_CMD_READ, 8'h10, 2);
        run_request(1, `XFCP_CMD_WRITE, 8'h80, 3);
        run_request(2, `XFCP_CMD_READ, 8'h40, 3);
        wait_responses();
        rand_ready = 1'b0;
        for (t = 0; t < 50; t++) begin
            @(negedge clk);
        end
        if (rsp_count - start != 3) begin
            $display("ERR %s response count expected 3 actual %0d",
                     test_name, rsp_count - start);
            err_count++;
        end
        end_test();

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
